// File: Makefile
.PHONY: all lint clean

all:
	verilator --binary --assert -j 0 --top-module duckHuntTb -f files.f -o duckHuntSim
	@out=$$(./obj_dir/duckHuntSim); \
	echo "$$out"; \
	echo "$$out" | grep -qF '*** PASSED ***'

lint:
	verilator --lint-only -Wall --top-module duckHuntTop -f files.f

clean:
	rm -rf obj_dir

// File: files.f
+incdir+sim
verilog/duckFieldPkg.sv
verilog/duckSpritePkg.sv
verilog/shotReceiver.sv
verilog/flightSequencer.sv
verilog/duckMotion.sv
verilog/spriteFrameSelect.sv
verilog/duckHuntTop.sv
sim/duckHuntTb.sv

// File: sim/duckHuntModel.svh
`ifndef DUCK_HUNT_MODEL_SVH
`define DUCK_HUNT_MODEL_SVH

// Expected duck right after a spawn load
function automatic duckState_t spawnedDuck(input spawnSeed_t seed);
	duckState_t d;
	d.x = seed.startX;
	d.y = 10'd300;
	d.heading = heading_t'({1'b0, seed.direction});
	d.color = (seed.color == 2'd3) ? 2'd0 : seed.color;	// Code 3 shows as Black
	return d;
endfunction

function automatic duckState_t steppedDuck(input duckState_t d);
	duckState_t r;
	int dx;
	int dy;
	case (d.heading)
		NW:
		begin
			dx = -12;
			dy = -10;
		end
		W:
		begin
			dx = -15;
			dy = -2;
		end
		NE:
		begin
			dx = 12;
			dy = -10;
		end
		E:
		begin
			dx = 15;
			dy = -2;
		end
		SW:
		begin
			dx = -12;
			dy = 10;
		end
		default:	// SE
		begin
			dx = 12;
			dy = 10;
		end
	endcase
	r = d;
	r.x = coord_t'(int'(d.x) + dx);
	r.y = coord_t'(int'(d.y) + dy);
	return r;
endfunction

function automatic heading_t reflectedHeading(input heading_t h, input coord_t y);
	heading_t r;
	case (h)
		NW: r = (y <= 10'd5) ? SW : NE;
		W: r = (y <= 10'd5) ? SW : E;
		NE: r = (y <= 10'd5) ? SE : NW;
		E: r = (y <= 10'd5) ? SE : W;
		SW: r = (y >= 10'd231) ? NW : SE;
		default: r = (y >= 10'd231) ? NE : SW;
	endcase
	return r;
endfunction

function automatic logic [5:0] byColor(input logic [1:0] c, input int b, input int r, input int p);
	logic [5:0] v;
	case (c)
		2'd1: v = 6'(r);
		2'd2: v = 6'(p);
		default: v = 6'(b);	// Black and code 3
	endcase
	return v;
endfunction

function automatic logic [5:0] frameLookup(input playMode_t m, input duckState_t d,
	input logic [1:0] flap);
	logic [5:0] base;
	logic west;
	west = (d.heading == NW) || (d.heading == W) || (d.heading == SW);
	case (d.heading)
		NW, SW: base = byColor(d.color, 11, 31, 51);
		W: base = byColor(d.color, 15, 35, 55);
		NE, SE: base = byColor(d.color, 0, 20, 40);
		default: base = byColor(d.color, 4, 24, 44);
	endcase
	case (m)
		Flying: return base + {4'd0, flap};
		Bouncing: return base;
		Shocked: return west ? byColor(d.color, 19, 39, 59) : byColor(d.color, 8, 28, 48);
		Falling: return west ? byColor(d.color, 10, 29, 50) : byColor(d.color, 9, 30, 49);
		default: return 6'd0;
	endcase
endfunction

`endif

// File: sim/duckHuntTb.sv
`timescale 1ns/1ps
`default_nettype none

module duckHuntTb;
	import duckFieldPkg::*;
	import duckSpritePkg::*;

	`include "duckHuntModel.svh"

	localparam int CycleLimit = NumDucks * (200 + HitHoldCycles + 40) + 200;

	typedef struct packed {
		gameStatus_t status;
		duckState_t duck;
		spawnSeed_t seed;
		logic [5:0] frame;
		logic ack;
	} snapshot_t;

	logic ANIM_Clk;
	logic Reset;
	logic run;
	logic shotReq;
	spawnSeed_t spawnSeed;
	logic shotAck;
	duckState_t duck;
	gameStatus_t status;
	logic [FrameWidth-1:0] duckFrame;

	logic [15:0] lfsr;
	logic [3:0] gunDice;	// Random gun timing
	int valueErrors;
	int otherErrors;
	int cycles;

	duckHuntTop u_duckHuntTop (
		.ANIM_Clk(ANIM_Clk),
		.Reset(Reset),
		.run(run),
		.shotReq(shotReq),
		.spawnSeed(spawnSeed),
		.shotAck(shotAck),
		.duck(duck),
		.status(status),
		.duckFrame(duckFrame)
	);

	// Fibonacci LFSR with taps 16 14 13 11
	function automatic logic [15:0] randBits(input int n);
		logic [15:0] v;
		logic fb;
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
			lfsr = {lfsr[14:0], fb};
			v = {v[14:0], fb};
		end
		return v;
	endfunction

	task automatic checkValue(input string name, input logic [31:0] got, input logic [31:0] exp);
		assert (got === exp)
		else
		begin
			valueErrors++;
			$display("[ERROR] %s: got 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
		end
	endtask

	//////////////////////////////
	// Clock, seed and timeout
	//////////////////////////////
	initial
	begin
		ANIM_Clk = 1'b0;
		forever #2 ANIM_Clk = ~ANIM_Clk;
	end

	initial
	begin
		spawnSeed = '0;
		gunDice = '0;
		lfsr = 16'd51962;
		forever
		begin
			@(posedge ANIM_Clk);
			spawnSeed <= spawnSeed_t'(randBits(16));	// Fresh seed every cycle
			gunDice <= 4'(randBits(4));
		end
	end

	initial
	begin
		cycles = 0;
		forever
		begin
			@(posedge ANIM_Clk);
			cycles++;
			if (cycles > CycleLimit)
			begin
				$display("Timeout: the game did not finish within %0d cycles", CycleLimit);
				$display("*** FAILED ***");
				$finish;
			end
		end
	end

	//////////////////////////////
	// Gun side
	//////////////////////////////
	task automatic fireShot();
		@(posedge ANIM_Clk);
		shotReq <= 1'b1;
		@(negedge ANIM_Clk);
		checkValue("shotAck", 32'(shotAck), 32'd0);	// Req not sampled yet
		@(negedge ANIM_Clk);
		checkValue("shotAck", 32'(shotAck), 32'd1);
		@(posedge ANIM_Clk);
		shotReq <= 1'b0;
		@(negedge ANIM_Clk);
		checkValue("shotAck", 32'(shotAck), 32'd1);
		@(negedge ANIM_Clk);
		checkValue("shotAck", 32'(shotAck), 32'd0);
	endtask

	initial
	begin
		Reset = 1'b1;
		run = 1'b0;
		shotReq = 1'b0;
		valueErrors = 0;
		otherErrors = 0;
		repeat (5) @(posedge ANIM_Clk);
		Reset <= 1'b0;
		fireShot();	// Lands in Idle
		@(posedge ANIM_Clk);
		run <= 1'b1;
		@(posedge ANIM_Clk);
		run <= 1'b0;
		while (status.mode != Over)
		begin
			@(negedge ANIM_Clk);
			if (status.mode == Flying)
			begin
				repeat (int'(gunDice[2:0])) @(negedge ANIM_Clk);
				fireShot();
			end
			else if (((status.mode == Shocked) || (status.mode == Falling)) &&
				(gunDice[3:1] == 3'd0))
				fireShot();	// Miss
		end
		repeat (3) fireShot();
		repeat (10) @(posedge ANIM_Clk);
		@(negedge ANIM_Clk);
		checkValue("status.kills", 32'(status.kills), 32'h3ff);
		checkValue("status.mode", 32'(status.mode), 32'(Over));
		$display("Checks done: %0d value errors, %0d other errors", valueErrors, otherErrors);
		if ((valueErrors == 0) && (otherErrors == 0))
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

	//////////////////////////////
	// Checking process
	//////////////////////////////
	initial
	begin
		snapshot_t prev;
		snapshot_t cur;
		duckState_t expDuck;
		logic [9:0] expKills;
		logic [1:0] flapPrev;
		logic [2:0] flyCnt;	// Moves since spawn or turn
		logic shotWaiting;
		int shockRun;
		prev = '0;
		flapPrev = 2'd0;
		flyCnt = 3'd0;
		shotWaiting = 1'b0;
		shockRun = 0;
		forever
		begin
			@(negedge ANIM_Clk);
			cur.status = status;
			cur.duck = duck;
			cur.seed = spawnSeed;
			cur.frame = duckFrame;
			cur.ack = shotAck;
			if (Reset)
			begin
				checkValue("shotAck", 32'(cur.ack), 32'd0);
				checkValue("status.mode", 32'(cur.status.mode), 32'(Idle));
				checkValue("status.kills", 32'(cur.status.kills), 32'd0);
				checkValue("status.duckNumber", 32'(cur.status.duckNumber), 32'd0);
				checkValue("duckFrame", 32'(cur.frame), 32'd0);
				flapPrev = 2'd0;
				flyCnt = 3'd0;
				shotWaiting = 1'b0;
			end
			else
			begin
				checkValue("duckFrame", 32'(cur.frame),
					32'(frameLookup(prev.status.mode, prev.duck, flapPrev)));
				flapPrev = (prev.status.mode == Flying) ? flapPrev + 2'd1 : 2'd0;
				if ((cur.status.mode == Flying) &&
					((prev.status.mode == Idle) || (prev.status.mode == Falling)))
				begin
					checkValue("duck", 32'(cur.duck), 32'(spawnedDuck(prev.seed)));
					checkValue("status.duckNumber", 32'(cur.status.duckNumber),
						32'(prev.status.duckNumber + 4'd1));
					flyCnt = 3'd0;
				end
				else if ((prev.status.mode == Flying) && (cur.status.mode == Flying))
				begin
					if (flyCnt == 3'(prev.seed.repeats) + 3'(RepeatBias))
					begin
						expDuck = prev.duck;	// Turn
						expDuck.heading = heading_t'({1'b0, prev.seed.direction});
						flyCnt = 3'd0;
					end
					else
					begin
						expDuck = steppedDuck(prev.duck);
						flyCnt = flyCnt + 3'd1;
					end
					checkValue("duck", 32'(cur.duck), 32'(expDuck));
				end
				else if (cur.status.mode == Bouncing)
				begin
					expDuck = prev.duck;
					expDuck.heading = reflectedHeading(prev.duck.heading, prev.duck.y);
					checkValue("duck", 32'(cur.duck), 32'(expDuck));
				end
				else if ((cur.status.mode == Falling) && (prev.status.mode == Falling))
					checkValue("duck.y", 32'(cur.duck.y), 32'(prev.duck.y + 10'd10));
				else if ((cur.status.mode != Over) || (prev.status.mode != Falling))
					checkValue("duck", 32'(cur.duck), 32'(prev.duck));	// Holds
				if (prev.status.mode == Flying)
				begin
					if (shotWaiting)
						checkValue("status.mode", 32'(cur.status.mode), 32'(Shocked));
					else
					begin
						assert (cur.status.mode != Shocked)
						else
						begin
							otherErrors++;
							$display("Duck was shocked with no shot pending at %0t", $time);
						end
					end
				end
				if (cur.ack && !prev.ack)
					shotWaiting = 1'b1;	// Shot taken in with the rise of ack
				else if ((prev.status.mode != Idle) && (prev.status.mode != Over))
					shotWaiting = 1'b0;
				if (cur.status.mode == Shocked)
					shockRun = (prev.status.mode == Shocked) ? shockRun + 1 : 1;
				if ((prev.status.mode == Shocked) && (cur.status.mode == Falling))
					checkValue("shockedCycles", 32'(shockRun), 32'(HitHoldCycles));
				expKills = prev.status.kills;
				if ((prev.status.mode == Falling) && (cur.status.mode != Falling))
				begin
					assert (prev.duck.y > 10'd300)
					else
					begin
						otherErrors++;
						$display("Falling duck left Falling before reaching the ground at %0t", $time);
					end
					expKills[prev.status.duckNumber - 4'd1] = 1'b1;
				end
				checkValue("status.kills", 32'(cur.status.kills), 32'(expKills));
				if (prev.status.mode == Over)
					checkValue("status.mode", 32'(cur.status.mode), 32'(Over));
			end
			prev = cur;
		end
	end

endmodule

`default_nettype wire

// File: verilog/duckFieldPkg.sv
`default_nettype none

package duckFieldPkg;

	//////////////////////////////
	// Screen geometry
	//////////////////////////////
	localparam int CoordWidth = 10;

	typedef logic [CoordWidth-1:0] coord_t;

	localparam coord_t FieldMinX = 10'd0;
	localparam coord_t FieldMinY = 10'd0;
	localparam coord_t FieldMaxX = 10'd576;
	localparam coord_t FieldMaxY = 10'd236;
	localparam coord_t TopMarginY = 10'd5;	// Reflection thresholds
	localparam coord_t BottomMarginY = 10'd231;
	localparam coord_t SpawnY = 10'd300;	// Ducks rise out of the grass
	localparam coord_t GroundY = 10'd300;

	localparam coord_t StepLargeX = 10'd15;
	localparam coord_t StepSmallX = 10'd12;
	localparam coord_t StepLargeY = 10'd10;
	localparam coord_t StepSmallY = 10'd2;
	localparam coord_t FallStep = 10'd10;

	//////////////////////////////
	// Duck state
	//////////////////////////////
	typedef enum logic [2:0] {NW, W, NE, E, SW, SE} heading_t;

	typedef struct packed {
		coord_t x;
		coord_t y;
		heading_t heading;
		logic [1:0] color;	// Sprite color code
	} duckState_t;

	typedef struct packed {
		coord_t startX;
		logic [1:0] direction;	// Only the four upward headings
		logic [1:0] color;
		logic [1:0] repeats;	// Steps before a random turn
	} spawnSeed_t;

	typedef enum logic [2:0] {Hold, Spawn, Move, Turn, Reflect, Fall} motionCmd_t;

endpackage

`default_nettype wire

// File: verilog/duckHuntTop.sv
`timescale 1ns/1ps
`default_nettype none

module duckHuntTop
(
	input  logic ANIM_Clk,
	input  logic Reset,
	input  logic run,
	input  logic shotReq,
	input  duckFieldPkg::spawnSeed_t spawnSeed,
	output logic shotAck,
	output duckFieldPkg::duckState_t duck,
	output duckSpritePkg::gameStatus_t status,
	output logic [duckSpritePkg::FrameWidth-1:0] duckFrame
);
	import duckFieldPkg::*;

	logic shotPending;
	logic shotTaken;
	motionCmd_t motionCmd;
	logic wallContact;
	logic landed;

	shotReceiver u_shotReceiver (	// Gun side
		.ANIM_Clk(ANIM_Clk),
		.Reset(Reset),
		.shotReq(shotReq),
		.shotTaken(shotTaken),
		.shotAck(shotAck),
		.shotPending(shotPending)
	);

	flightSequencer u_flightSequencer (
		.ANIM_Clk(ANIM_Clk),
		.Reset(Reset),
		.run(run),
		.shotPending(shotPending),
		.repeats(spawnSeed.repeats),
		.wallContact(wallContact),
		.landed(landed),
		.shotTaken(shotTaken),
		.motionCmd(motionCmd),
		.status(status)
	);

	duckMotion u_duckMotion (
		.ANIM_Clk(ANIM_Clk),
		.Reset(Reset),
		.motionCmd(motionCmd),
		.spawnSeed(spawnSeed),
		.duck(duck),
		.wallContact(wallContact),
		.landed(landed)
	);

	spriteFrameSelect u_spriteFrameSelect (	// Video side
		.ANIM_Clk(ANIM_Clk),
		.Reset(Reset),
		.status(status),
		.duck(duck),
		.duckFrame(duckFrame)
	);

endmodule

`default_nettype wire

// File: verilog/duckMotion.sv
`timescale 1ns/1ps
`default_nettype none

module duckMotion
(
	input  logic ANIM_Clk,
	input  logic Reset,
	input  duckFieldPkg::motionCmd_t motionCmd,
	input  duckFieldPkg::spawnSeed_t spawnSeed,
	output duckFieldPkg::duckState_t duck,
	output logic wallContact,
	output logic landed
);
	import duckFieldPkg::*;

	coord_t stepX, stepY;
	heading_t seedHeading;
	heading_t bounceHeading;
	logic [1:0] seedColor;

	// Upward headings turn down at the top, everything else mirrors sideways
	function automatic heading_t reflectHeading(input heading_t h, input coord_t y);
		heading_t r;
		case (h)
			NW: r = (y <= TopMarginY) ? SW : NE;
			W: r = (y <= TopMarginY) ? SW : E;
			NE: r = (y <= TopMarginY) ? SE : NW;
			E: r = (y <= TopMarginY) ? SE : W;
			SW: r = (y >= BottomMarginY) ? NW : SE;
			SE: r = (y >= BottomMarginY) ? NE : SW;
			default: r = h;
		endcase
		return r;
	endfunction

	assign seedHeading = heading_t'({1'b0, spawnSeed.direction});
	assign seedColor = (spawnSeed.color == 2'd3) ? 2'd0 : spawnSeed.color;	// Code 3 is Black
	assign bounceHeading = reflectHeading(duck.heading, duck.y);

	//////////////////////////////
	// One flight step
	//////////////////////////////
	always_comb
	begin
		stepX = duck.x;
		stepY = duck.y;
		case (duck.heading)
			NW:
			begin
				stepX = duck.x - StepSmallX;
				stepY = duck.y - StepLargeY;
			end
			W:
			begin
				stepX = duck.x - StepLargeX;
				stepY = duck.y - StepSmallY;	// Shallow climb
			end
			NE:
			begin
				stepX = duck.x + StepSmallX;
				stepY = duck.y - StepLargeY;
			end
			E:
			begin
				stepX = duck.x + StepLargeX;
				stepY = duck.y - StepSmallY;
			end
			SW:
			begin
				stepX = duck.x - StepSmallX;
				stepY = duck.y + StepLargeY;
			end
			SE:
			begin
				stepX = duck.x + StepSmallX;
				stepY = duck.y + StepLargeY;
			end
			default: ;
		endcase
	end

	always_ff @(posedge ANIM_Clk or posedge Reset)
	begin
		if (Reset)
		begin
			duck.x <= 10'd400;	// Parked in the grass
			duck.y <= SpawnY;
			duck.heading <= NW;
			duck.color <= 2'd0;
		end
		else
		begin
			case (motionCmd)
				Spawn:
				begin
					duck.x <= spawnSeed.startX;
					duck.y <= SpawnY;
					duck.heading <= seedHeading;
					duck.color <= seedColor;
				end
				Move:
				begin
					duck.x <= stepX;
					duck.y <= stepY;
				end
				Turn: duck.heading <= seedHeading;
				Reflect: duck.heading <= bounceHeading;
				Fall: duck.y <= duck.y + FallStep;
				default: ;
			endcase
		end
	end

	assign wallContact = (duck.x <= FieldMinX) || (duck.x >= FieldMaxX) ||
		(duck.y <= FieldMinY) || (duck.y >= FieldMaxY);
	assign landed = (duck.y > GroundY);

endmodule

`default_nettype wire

// File: verilog/duckSpritePkg.sv
`default_nettype none

package duckSpritePkg;

	typedef enum logic [1:0] {Black, Red, Pink} duckColor_t;

	localparam int FrameWidth = 6;

	//////////////////////////////
	// Frame bases by color
	//////////////////////////////
	// Entry 3 repeats Black
	localparam logic [3:0][FrameWidth-1:0] FlyBaseNwSw = {6'd11, 6'd51, 6'd31, 6'd11};
	localparam logic [3:0][FrameWidth-1:0] FlyBaseW = {6'd15, 6'd55, 6'd35, 6'd15};
	localparam logic [3:0][FrameWidth-1:0] FlyBaseNeSe = {6'd0, 6'd40, 6'd20, 6'd0};
	localparam logic [3:0][FrameWidth-1:0] FlyBaseE = {6'd4, 6'd44, 6'd24, 6'd4};
	localparam logic [3:0][FrameWidth-1:0] ShockWest = {6'd19, 6'd59, 6'd39, 6'd19};
	localparam logic [3:0][FrameWidth-1:0] ShockEast = {6'd8, 6'd48, 6'd28, 6'd8};
	localparam logic [3:0][FrameWidth-1:0] FallWest = {6'd10, 6'd50, 6'd29, 6'd10};
	localparam logic [3:0][FrameWidth-1:0] FallEast = {6'd9, 6'd49, 6'd30, 6'd9};

	typedef enum logic [2:0] {Idle, Flying, Bouncing, Shocked, Falling, Over} playMode_t;

	typedef struct packed {
		playMode_t mode;
		logic [3:0] duckNumber;	// Ducks spawned so far
		logic [9:0] kills;	// One bit per duck
	} gameStatus_t;

	localparam int NumDucks = 10;
	localparam int HitHoldCycles = 15;
	localparam int BounceCooldown = 4;
	localparam int RepeatBias = 3;

endpackage

`default_nettype wire

// File: verilog/flightSequencer.sv
`timescale 1ns/1ps
`default_nettype none

module flightSequencer
(
	input  logic ANIM_Clk,
	input  logic Reset,
	input  logic run,
	input  logic shotPending,
	input  logic [1:0] repeats,
	input  logic wallContact,
	input  logic landed,
	output logic shotTaken,
	output duckFieldPkg::motionCmd_t motionCmd,
	output duckSpritePkg::gameStatus_t status
);
	import duckFieldPkg::*;
	import duckSpritePkg::*;

	playMode_t mode, modeNext;
	logic startArmed;
	logic [3:0] duckNumber;
	logic [9:0] kills;
	logic [2:0] flyCount;	// Moves since the last turn
	logic [2:0] cooldown;
	logic [3:0] holdCount;
	logic [2:0] flyLimit;
	logic lastDuck;

	assign flyLimit = {1'b0, repeats} + 3'(RepeatBias);
	assign lastDuck = (duckNumber >= 4'(NumDucks));
	assign status = '{mode: mode, duckNumber: duckNumber, kills: kills};

	//////////////////////////////
	// Next mode and motion command
	//////////////////////////////
	always_comb
	begin
		modeNext = mode;
		motionCmd = Hold;
		shotTaken = 1'b0;
		case (mode)
			Idle:
			begin
				if (startArmed)
				begin
					motionCmd = Spawn;	// First duck
					modeNext = Flying;
				end
			end
			Flying:
			begin
				shotTaken = shotPending;
				if (shotPending)
					modeNext = Shocked;	// Hit, position holds
				else if (wallContact && (cooldown == 3'd0))
				begin
					motionCmd = Reflect;
					modeNext = Bouncing;
				end
				else if (flyCount == flyLimit)
					motionCmd = Turn;
				else
					motionCmd = Move;
			end
			Bouncing:
			begin
				shotTaken = shotPending;	// Miss
				modeNext = Flying;
			end
			Shocked:
			begin
				shotTaken = shotPending;
				if (holdCount == 4'(HitHoldCycles - 1))
					modeNext = Falling;
			end
			Falling:
			begin
				shotTaken = shotPending;
				if (landed)
				begin
					if (lastDuck)
						modeNext = Over;
					else
					begin
						motionCmd = Spawn;	// Next duck comes straight up
						modeNext = Flying;
					end
				end
				else
					motionCmd = Fall;
			end
			default: ;	// Over holds until reset
		endcase
	end

	//////////////////////////////
	// Counters and tally
	//////////////////////////////
	always_ff @(posedge ANIM_Clk or posedge Reset)
	begin
		if (Reset)
		begin
			mode <= Idle;
			startArmed <= 1'b0;
			duckNumber <= 4'd0;
			kills <= 10'd0;
			flyCount <= 3'd0;
			cooldown <= 3'd0;
			holdCount <= 4'd0;
		end
		else
		begin
			mode <= modeNext;
			startArmed <= (mode == Idle) && run && !startArmed;	// One cycle of delay before spawn
			case (motionCmd)
				Spawn:
				begin
					duckNumber <= duckNumber + 4'd1;
					flyCount <= 3'd0;
					cooldown <= 3'd0;
				end
				Move:
				begin
					flyCount <= flyCount + 3'd1;
					if (cooldown != 3'd0)
						cooldown <= cooldown - 3'd1;
				end
				Turn: flyCount <= 3'd0;
				Reflect: cooldown <= 3'(BounceCooldown);
				default: ;
			endcase
			if (mode == Shocked)
				holdCount <= holdCount + 4'd1;
			else
				holdCount <= 4'd0;
			if ((mode == Falling) && landed)
				kills[duckNumber - 4'd1] <= 1'b1;	// Duck numbers start at 1
		end
	end

endmodule

`default_nettype wire

// File: verilog/shotReceiver.sv
`timescale 1ns/1ps
`default_nettype none

module shotReceiver
(
	input  logic ANIM_Clk,
	input  logic Reset,
	input  logic shotReq,
	input  logic shotTaken,
	output logic shotAck,
	output logic shotPending
);

	typedef enum logic {AckLow, AckHigh} ackState_t;

	ackState_t ackState, ackNext;
	logic newShot;

	always_comb
	begin
		ackNext = ackState;
		case (ackState)
			AckLow: if (shotReq) ackNext = AckHigh;
			AckHigh: if (!shotReq) ackNext = AckLow;
			default: ackNext = AckLow;
		endcase
	end

	assign newShot = (ackState == AckLow) && shotReq;	// Rising phase of the handshake
	assign shotAck = (ackState == AckHigh);

	always_ff @(posedge ANIM_Clk or posedge Reset)
	begin
		if (Reset)
		begin
			ackState <= AckLow;
			shotPending <= 1'b0;
		end
		else
		begin
			ackState <= ackNext;
			if (newShot)
				shotPending <= 1'b1;	// A fresh shot wins over a take
			else if (shotTaken)
				shotPending <= 1'b0;
		end
	end

endmodule

`default_nettype wire

// File: verilog/spriteFrameSelect.sv
`timescale 1ns/1ps
`default_nettype none

module spriteFrameSelect
(
	input  logic ANIM_Clk,
	input  logic Reset,
	input  duckSpritePkg::gameStatus_t status,
	input  duckFieldPkg::duckState_t duck,
	output logic [duckSpritePkg::FrameWidth-1:0] duckFrame
);
	import duckFieldPkg::*;
	import duckSpritePkg::*;

	logic [1:0] flap;	// Wing position
	duckColor_t color;
	logic westGoing;
	logic [FrameWidth-1:0] flyBase;
	logic [FrameWidth-1:0] frameNext;

	assign color = duckColor_t'(duck.color);
	assign westGoing = (duck.heading == NW) || (duck.heading == W) || (duck.heading == SW);

	always_comb
	begin
		case (duck.heading)
			NW, SW: flyBase = FlyBaseNwSw[color];
			W: flyBase = FlyBaseW[color];
			NE, SE: flyBase = FlyBaseNeSe[color];
			E: flyBase = FlyBaseE[color];
			default: flyBase = '0;
		endcase
	end

	//////////////////////////////
	// Frame lookup by pose
	//////////////////////////////
	always_comb
	begin
		case (status.mode)
			Flying: frameNext = flyBase + {4'd0, flap};
			Bouncing: frameNext = flyBase;	// Wings held during the turn
			Shocked: frameNext = westGoing ? ShockWest[color] : ShockEast[color];
			Falling: frameNext = westGoing ? FallWest[color] : FallEast[color];
			default: frameNext = '0;
		endcase
	end

	always_ff @(posedge ANIM_Clk or posedge Reset)
	begin
		if (Reset)
		begin
			flap <= 2'd0;
			duckFrame <= '0;
		end
		else
		begin
			if (status.mode == Flying)
				flap <= flap + 2'd1;	// Wraps after four frames
			else
				flap <= 2'd0;
			duckFrame <= frameNext;
		end
	end

endmodule

`default_nettype wire
